// ==== datapath.f ====
+incdir+common
common/datapath_pkg.sv
operand_bank/ram_sdp.sv
operand_bank/io_read_port.sv
operand_bank/io_write_port.sv
operand_bank/operand_bank.sv
design/issue_stage.sv
design/alu.sv
design/datapath.sv
tests/datapath_tb.sv

// ==== tests/datapath_tb.sv ====
`timescale 1ns/1ps

`include "datapath_defs.svh"

module datapath_tb;

    localparam int RESET_CYCLES = 5;
    localparam int N_SLOTS      = 8;
    localparam int N_RANDOM     = 20;
    localparam int N_OPS        = 3 * N_SLOTS + N_RANDOM + 2 + 3 + 2;
    // Each operation spans three rising edges.
    localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + 2 + 3 * N_OPS);

    logic                           clock;
    logic                           arst_n;
    datapath_pkg::instr_t           instr;
    logic                           cancel;
    logic                           io_ready;
    datapath_pkg::io_in_t           a_io_in;
    datapath_pkg::io_in_t           b_io_in;
    logic [`DP_IO_PORTS-1:0]        a_io_rden;
    logic [`DP_IO_PORTS-1:0]        b_io_rden;
    logic [`DP_IO_PORTS-1:0]        a_io_out_ready;
    logic [`DP_IO_PORTS-1:0]        b_io_out_ready;
    datapath_pkg::io_out_t          a_io_out;
    datapath_pkg::io_out_t          b_io_out;
    datapath_pkg::wb_t              alu_wb;

    // Reference model state. Index 0 is bank A and 1 is bank B.
    logic [15:0]    ram [2][256];
    logic [15:0]    in_word [2][2];
    logic [1:0]     in_ready [2];
    logic [1:0]     out_ready [2];

    datapath_pkg::opcode_e  rand_op;
    int                     errors = 0;
    int                     errors_at_start = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    int                     cycles = 0;

    datapath DUT (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Reference model.
    // --------------------------------------------------

    function automatic logic [15:0] alu_ref(input datapath_pkg::opcode_e op,
                                            input logic [15:0] a, input logic [15:0] b);
        case (op)
            datapath_pkg::OP_ADD:    return a + b;
            datapath_pkg::OP_SUB:    return a - b;
            datapath_pkg::OP_AND:    return a & b;
            datapath_pkg::OP_OR:     return a | b;
            datapath_pkg::OP_XOR:    return a ^ b;
            datapath_pkg::OP_PASS_A: return a;
            default:                 return 16'h0;
        endcase
    endfunction

    function automatic logic [15:0] read_ref(input int bank, input logic [8:0] addr);
        if (addr < 9'd256) return ram[bank][addr[7:0]];
        if (addr[8:1] == 8'hFF) return in_word[bank][addr[0]];
        return 16'h0;
    endfunction

    function automatic logic [1:0] wren_ref(input int offset, input logic [9:0] d,
                                            input logic writes);
        logic [9:0] rel;
        rel = d - 10'(offset);
        if (writes && !rel[9] && rel[8:1] == 8'hFF) return 2'b01 << rel[0];
        return 2'b00;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        assert (got === expv) else begin
            $display("[ERROR] %s: got %h expected %h", name, got, expv);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // One instruction, from issue to write-back.
    // --------------------------------------------------

    task automatic run_op(input datapath_pkg::opcode_e op, input logic [9:0] d,
                          input logic [8:0] a, input logic [8:0] b,
                          input logic cxl, input logic expect_go);
        logic [15:0]    exp_res;
        logic           writes;
        logic [1:0]     a_wren;
        logic [1:0]     b_wren;
        @(posedge clock);
        instr          <= {op, d, a, b};
        cancel         <= cxl;
        a_io_in        <= {in_ready[0], in_word[0][1], in_word[0][0]};
        b_io_in        <= {in_ready[1], in_word[1][1], in_word[1][0]};
        a_io_out_ready <= out_ready[0];
        b_io_out_ready <= out_ready[1];
        exp_res = alu_ref(op, read_ref(0, a), read_ref(1, b));
        writes  = expect_go && (op != datapath_pkg::OP_NOP);
        a_wren  = wren_ref(`DP_A_OFFSET, d, writes);
        b_wren  = wren_ref(`DP_B_OFFSET, d, writes);
        @(negedge clock);
        check_value("io_ready", io_ready, expect_go);
        check_value("a_io_rden", a_io_rden,
                    (expect_go && a[8:1] == 8'hFF) ? 2'b01 << a[0] : 2'b00);
        check_value("b_io_rden", b_io_rden,
                    (expect_go && b[8:1] == 8'hFF) ? 2'b01 << b[0] : 2'b00);
        @(posedge clock);
        instr  <= '0;
        cancel <= 1'b0;
        // A pop lasts exactly the presenting cycle.
        @(negedge clock);
        check_value("a_io_rden", a_io_rden, 2'b00);
        check_value("b_io_rden", b_io_rden, 2'b00);
        @(posedge clock);
        @(negedge clock);
        check_value("alu_wb.write", alu_wb.write, writes);
        if (writes) begin
            check_value("alu_wb.d", alu_wb.d, d);
            check_value("alu_wb.result", alu_wb.result, exp_res);
            if (d[8:0] < 9'd256) ram[d[9]][d[7:0]] = exp_res;
        end
        check_value("a_io_out.wren", a_io_out.wren, a_wren);
        check_value("b_io_out.wren", b_io_out.wren, b_wren);
        if (a_wren != 2'b00) check_value("a_io_out.data", a_io_out.data, exp_res);
        if (b_wren != 2'b00) check_value("b_io_out.data", b_io_out.data, exp_res);
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d checks failed", tests_run, name,
                     errors - errors_at_start);
        end
    endtask

    // --------------------------------------------------
    // Test sequence.
    // --------------------------------------------------

    initial begin
        void'($urandom(32'h6bfd6fdd));
        arst_n = 1'b0;
        instr = '0;
        cancel = 1'b0;
        a_io_in = '0;
        b_io_in = '0;
        a_io_out_ready = '0;
        b_io_out_ready = '0;
        for (int bk = 0; bk < 2; bk++) begin
            in_ready[bk]   = 2'b11;
            out_ready[bk]  = 2'b11;
            in_word[bk][0] = 16'h0;
            in_word[bk][1] = 16'h0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        arst_n <= 1'b1;

        start_test();
        @(negedge clock);
        check_value("a_io_rden", a_io_rden, 2'b00);
        check_value("b_io_rden", b_io_rden, 2'b00);
        check_value("a_io_out.wren", a_io_out.wren, 2'b00);
        check_value("b_io_out.wren", b_io_out.wren, 2'b00);
        check_value("alu_wb.write", alu_wb.write, 1'b0);
        end_test("reset state");

        start_test();
        for (int i = 0; i < N_SLOTS; i++) begin
            in_word[0][0] = 16'($urandom);
            run_op(datapath_pkg::OP_PASS_A, 10'(i), 9'h1FE, 9'h000, 1'b0, 1'b1);
        end
        // Local 0x100 is unmapped, so the ADD passes the B word.
        for (int i = 0; i < N_SLOTS; i++) begin
            in_word[1][1] = 16'($urandom);
            run_op(datapath_pkg::OP_ADD, 10'(512 + i), 9'h100, 9'h1FF, 1'b0, 1'b1);
        end
        end_test("I/O words into RAM");

        start_test();
        for (int k = 0; k < N_RANDOM; k++) begin
            rand_op = datapath_pkg::opcode_e'(1 + $urandom % 5);
            run_op(rand_op, 10'(520 + k % N_SLOTS), 9'($urandom % N_SLOTS),
                   9'($urandom % N_SLOTS), 1'b0, 1'b1);
        end
        for (int j = 0; j < N_SLOTS; j++) begin
            run_op(datapath_pkg::OP_ADD, 10'(100 + j), 9'h100, 9'(8 + j), 1'b0, 1'b1);
        end
        end_test("ALU ops on RAM");

        start_test();
        run_op(datapath_pkg::OP_PASS_A, 10'h1FE, 9'h000, 9'h000, 1'b0, 1'b1);
        run_op(datapath_pkg::OP_ADD, 10'h3FF, 9'h001, 9'h002, 1'b0, 1'b1);
        end_test("I/O write ports");

        start_test();
        in_ready[0] = 2'b10;
        run_op(datapath_pkg::OP_PASS_A, 10'd40, 9'h1FE, 9'h000, 1'b0, 1'b0);
        in_ready[0] = 2'b11;
        in_ready[1] = 2'b01;
        run_op(datapath_pkg::OP_ADD, 10'd41, 9'h000, 9'h1FF, 1'b0, 1'b0);
        in_ready[1] = 2'b11;
        out_ready[1] = 2'b01;
        run_op(datapath_pkg::OP_ADD, 10'h3FF, 9'h000, 9'h001, 1'b0, 1'b0);
        out_ready[1] = 2'b11;
        end_test("back-pressure annul");

        start_test();
        run_op(datapath_pkg::OP_XOR, 10'd42, 9'h003, 9'h004, 1'b1, 1'b0);
        run_op(datapath_pkg::OP_XOR, 10'd42, 9'h003, 9'h004, 1'b0, 1'b1);
        end_test("cancel and re-issue");

        $display("%0d tests run, %0d failed, %0d failing checks",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== design/datapath.sv ====
`timescale 1ns/1ps

`include "datapath_defs.svh"

module datapath (
    input  logic                        clock,
    input  logic                        arst_n,

    input  datapath_pkg::instr_t        instr,
    input  logic                        cancel,
    output logic                        io_ready,

    input  datapath_pkg::io_in_t        a_io_in,
    output logic [`DP_IO_PORTS-1:0]     a_io_rden,
    input  logic [`DP_IO_PORTS-1:0]     a_io_out_ready,
    output datapath_pkg::io_out_t       a_io_out,

    input  datapath_pkg::io_in_t        b_io_in,
    output logic [`DP_IO_PORTS-1:0]     b_io_rden,
    input  logic [`DP_IO_PORTS-1:0]     b_io_out_ready,
    output datapath_pkg::io_out_t       b_io_out,

    output datapath_pkg::wb_t           alu_wb
);

    logic                           a_read_ok;
    logic                           a_write_ok;
    logic                           b_read_ok;
    logic                           b_write_ok;
    logic [`DP_WORD_WIDTH-1:0]      a_operand;
    logic [`DP_WORD_WIDTH-1:0]      b_operand;
    datapath_pkg::alu_req_t         req;

    // --------------------------------------------------
    // Issue. All four I/O checks meet here.
    // --------------------------------------------------

    issue_stage u_issue (
        .clock      (clock),
        .arst_n     (arst_n),
        .instr      (instr),
        .cancel     (cancel),
        .a_read_ok  (a_read_ok),
        .b_read_ok  (b_read_ok),
        .a_write_ok (a_write_ok),
        .b_write_ok (b_write_ok),
        .io_ready   (io_ready),
        .req        (req)
    );

    // --------------------------------------------------
    // Operand banks.
    // --------------------------------------------------

    operand_bank #(
        .BANK_OFFSET    (`DP_A_OFFSET)
    ) u_bank_a (
        .clock          (clock),
        .arst_n         (arst_n),
        .read_addr      (instr.a),
        .d_issue        (instr.d),
        .go             (io_ready),
        .io_in          (a_io_in),
        .io_out_ready   (a_io_out_ready),
        .wb             (alu_wb),
        .read_ok        (a_read_ok),
        .write_ok       (a_write_ok),
        .io_rden        (a_io_rden),
        .operand        (a_operand),
        .io_out         (a_io_out)
    );

    operand_bank #(
        .BANK_OFFSET    (`DP_B_OFFSET)
    ) u_bank_b (
        .clock          (clock),
        .arst_n         (arst_n),
        .read_addr      (instr.b),
        .d_issue        (instr.d),
        .go             (io_ready),
        .io_in          (b_io_in),
        .io_out_ready   (b_io_out_ready),
        .wb             (alu_wb),
        .read_ok        (b_read_ok),
        .write_ok       (b_write_ok),
        .io_rden        (b_io_rden),
        .operand        (b_operand),
        .io_out         (b_io_out)
    );

    // --------------------------------------------------
    // ALU. Its output feeds back to both banks.
    // --------------------------------------------------

    alu u_alu (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (req),
        .a      (a_operand),
        .b      (b_operand),
        .wb     (alu_wb)
    );

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

`include "datapath_defs.svh"

module alu (
    input  logic                        clock,
    input  logic                        arst_n,
    input  datapath_pkg::alu_req_t      req,
    input  logic [`DP_WORD_WIDTH-1:0]   a,
    input  logic [`DP_WORD_WIDTH-1:0]   b,
    output datapath_pkg::wb_t           wb
);

    logic [`DP_WORD_WIDTH-1:0] result;

    // --------------------------------------------------
    // Operation select.
    // --------------------------------------------------

    // Results wrap at the word width.
    always_comb begin
        case (req.op)
            datapath_pkg::OP_ADD:    result = a + b;
            datapath_pkg::OP_SUB:    result = a - b;
            datapath_pkg::OP_AND:    result = a & b;
            datapath_pkg::OP_OR:     result = a | b;
            datapath_pkg::OP_XOR:    result = a ^ b;
            datapath_pkg::OP_PASS_A: result = a;
            default:                 result = '0;
        endcase
    end

    // --------------------------------------------------
    // Write-back register.
    // --------------------------------------------------

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb.write  <= 1'b0;
            wb.d      <= '0;
            wb.result <= '0;
        end else begin
            wb.write  <= (req.op != datapath_pkg::OP_NOP);
            wb.d      <= req.d;
            wb.result <= result;
        end
    end

endmodule

// ==== design/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
    input  logic                    clock,
    input  logic                    arst_n,
    input  datapath_pkg::instr_t    instr,
    input  logic                    cancel,
    input  logic                    a_read_ok,
    input  logic                    b_read_ok,
    input  logic                    a_write_ok,
    input  logic                    b_write_ok,
    output logic                    io_ready,
    output datapath_pkg::alu_req_t  req
);

    // Any blocked port or a cancel holds the whole instruction back.
    // The source sees io_ready low and presents it again.
    assign io_ready = a_read_ok & b_read_ok & a_write_ok & b_write_ok & ~cancel;

    // --------------------------------------------------
    // Request register, lined up with the bank reads.
    // --------------------------------------------------

    // An annulled instruction turns into a NOP here.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            req.op <= datapath_pkg::OP_NOP;
            req.d  <= '0;
        end else if (io_ready) begin
            req.op <= instr.op;
            req.d  <= instr.d;
        end else begin
            req.op <= datapath_pkg::OP_NOP;
            req.d  <= instr.d;
        end
    end

endmodule

// ==== operand_bank/operand_bank.sv ====
`timescale 1ns/1ps

`include "datapath_defs.svh"

module operand_bank #(
    parameter int unsigned BANK_OFFSET = `DP_A_OFFSET
) (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic [`DP_AB_WIDTH-1:0]     read_addr,
    input  logic [`DP_D_WIDTH-1:0]      d_issue,
    input  logic                        go,
    input  datapath_pkg::io_in_t        io_in,
    input  logic [`DP_IO_PORTS-1:0]     io_out_ready,
    input  datapath_pkg::wb_t           wb,
    output logic                        read_ok,
    output logic                        write_ok,
    output logic [`DP_IO_PORTS-1:0]     io_rden,
    output logic [`DP_WORD_WIDTH-1:0]   operand,
    output datapath_pkg::io_out_t       io_out
);

    logic                               ram_wren;
    logic [`DP_RAM_ADDR_WIDTH-1:0]      ram_write_addr;
    logic [`DP_WORD_WIDTH-1:0]          ram_read_data;

    // --------------------------------------------------
    // Storage. The low address bits index the RAM.
    // --------------------------------------------------

    ram_sdp u_ram (
        .clock      (clock),
        .wren       (ram_wren),
        .write_addr (ram_write_addr),
        .write_data (wb.result),
        .read_addr  (read_addr[`DP_RAM_ADDR_WIDTH-1:0]),
        .read_data  (ram_read_data)
    );

    // --------------------------------------------------
    // Read side.
    // --------------------------------------------------

    io_read_port u_read (
        .clock      (clock),
        .arst_n     (arst_n),
        .read_addr  (read_addr),
        .go         (go),
        .io_in      (io_in),
        .ram_data   (ram_read_data),
        .read_ok    (read_ok),
        .io_rden    (io_rden),
        .operand    (operand)
    );

    // --------------------------------------------------
    // Write side.
    // --------------------------------------------------

    io_write_port #(
        .BANK_OFFSET    (BANK_OFFSET)
    ) u_write (
        .d_issue        (d_issue),
        .io_out_ready   (io_out_ready),
        .wb             (wb),
        .write_ok       (write_ok),
        .ram_wren       (ram_wren),
        .ram_addr       (ram_write_addr),
        .io_out         (io_out)
    );

endmodule

// ==== operand_bank/io_write_port.sv ====
`timescale 1ns/1ps

`include "datapath_defs.svh"

module io_write_port #(
    parameter int unsigned BANK_OFFSET = `DP_A_OFFSET
) (
    input  logic [`DP_D_WIDTH-1:0]          d_issue,
    input  logic [`DP_IO_PORTS-1:0]         io_out_ready,
    input  datapath_pkg::wb_t               wb,
    output logic                            write_ok,
    output logic                            ram_wren,
    output logic [`DP_RAM_ADDR_WIDTH-1:0]   ram_addr,
    output datapath_pkg::io_out_t           io_out
);

    localparam logic [`DP_D_WIDTH-1:0] OFFSET = `DP_D_WIDTH'(BANK_OFFSET);

    logic [`DP_D_WIDTH-1:0]         issue_rel;
    logic [`DP_D_WIDTH-1:0]         wb_rel;
    logic                           issue_hit;
    logic                           wb_hit;
    datapath_pkg::local_addr_u      issue_local;
    datapath_pkg::local_addr_u      wb_local;

    // --------------------------------------------------
    // Localise D against this bank.
    // --------------------------------------------------

    // Addresses below the offset wrap high and miss the bank.
    assign issue_rel   = d_issue - OFFSET;
    assign wb_rel      = wb.d - OFFSET;
    assign issue_hit   = (issue_rel[`DP_D_WIDTH-1:`DP_AB_WIDTH] == '0);
    assign wb_hit      = (wb_rel[`DP_D_WIDTH-1:`DP_AB_WIDTH] == '0) & wb.write;
    assign issue_local = issue_rel[`DP_AB_WIDTH-1:0];
    assign wb_local    = wb_rel[`DP_AB_WIDTH-1:0];

    // Full check at issue, so one slot of slack covers the pipeline.
    assign write_ok = ~issue_hit
                    | (issue_local.io.tag != `DP_IO_TAG)
                    | io_out_ready[issue_local.io.port];

    // --------------------------------------------------
    // Write-back steering.
    // --------------------------------------------------

    assign ram_wren = wb_hit & ~wb_local.ram.io_flag;
    assign ram_addr = wb_local.ram.index;

    always_comb begin
        io_out.data = wb.result;
        for (int p = 0; p < `DP_IO_PORTS; p++) begin
            io_out.wren[p] = wb_hit & (wb_local.io.tag == `DP_IO_TAG)
                           & (wb_local.io.port == 1'(p));
        end
    end

endmodule

// ==== operand_bank/io_read_port.sv ====
`timescale 1ns/1ps

`include "datapath_defs.svh"

module io_read_port (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic [`DP_AB_WIDTH-1:0]     read_addr,
    input  logic                        go,
    input  datapath_pkg::io_in_t        io_in,
    input  logic [`DP_WORD_WIDTH-1:0]   ram_data,
    output logic                        read_ok,
    output logic [`DP_IO_PORTS-1:0]     io_rden,
    output logic [`DP_WORD_WIDTH-1:0]   operand
);

    datapath_pkg::local_addr_u      addr;
    logic                           is_ram;
    logic                           is_io;
    logic                           sel_ram;
    logic                           sel_io;
    logic [`DP_WORD_WIDTH-1:0]      io_word;

    // --------------------------------------------------
    // Address decode.
    // --------------------------------------------------

    assign addr   = read_addr;
    assign is_ram = ~addr.ram.io_flag;
    assign is_io  = (addr.io.tag == `DP_IO_TAG);

    // Only an addressed, empty port stalls the read.
    assign read_ok = ~is_io | io_in.ready[addr.io.port];

    // Pop strobe for the addressed port.
    always_comb begin
        for (int p = 0; p < `DP_IO_PORTS; p++) begin
            io_rden[p] = go & is_io & (addr.io.port == 1'(p));
        end
    end

    // --------------------------------------------------
    // Registered select, in step with the RAM read.
    // --------------------------------------------------

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sel_ram <= 1'b0;
            sel_io  <= 1'b0;
        end else begin
            sel_ram <= is_ram;
            sel_io  <= is_io;
        end
    end

    always_ff @(posedge clock) begin
        io_word <= io_in.data[addr.io.port];
    end

    // Unmapped addresses read as zero.
    assign operand = sel_ram ? ram_data :
                     sel_io  ? io_word  : '0;

endmodule

// ==== operand_bank/ram_sdp.sv ====
`timescale 1ns/1ps

`include "datapath_defs.svh"

module ram_sdp (
    input  logic                            clock,
    input  logic                            wren,
    input  logic [`DP_RAM_ADDR_WIDTH-1:0]   write_addr,
    input  logic [`DP_WORD_WIDTH-1:0]       write_data,
    input  logic [`DP_RAM_ADDR_WIDTH-1:0]   read_addr,
    output logic [`DP_WORD_WIDTH-1:0]       read_data
);

    logic [`DP_WORD_WIDTH-1:0] mem [`DP_RAM_DEPTH];

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // A read on the same edge as a write returns the old word.
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

endmodule

// ==== common/datapath_pkg.sv ====
`include "datapath_defs.svh"

package datapath_pkg;

    // --------------------------------------------------
    // Instruction encoding.
    // --------------------------------------------------

    typedef enum logic [`DP_OP_WIDTH-1:0] {
        OP_NOP    = 4'd0,
        OP_ADD    = 4'd1,
        OP_SUB    = 4'd2,
        OP_AND    = 4'd3,
        OP_OR     = 4'd4,
        OP_XOR    = 4'd5,
        OP_PASS_A = 4'd6
    } opcode_e;

    typedef struct packed {
        opcode_e                    op;
        logic [`DP_D_WIDTH-1:0]     d;
        logic [`DP_AB_WIDTH-1:0]    a;
        logic [`DP_AB_WIDTH-1:0]    b;
    } instr_t;

    // One local bank address, seen as a RAM index or as an I/O port select.
    typedef union packed {
        struct packed {
            logic                           io_flag;
            logic [`DP_RAM_ADDR_WIDTH-1:0]  index;
        } ram;
        struct packed {
            logic [`DP_AB_WIDTH-2:0]        tag;
            logic                           port;
        } io;
    } local_addr_u;

    // --------------------------------------------------
    // I/O port bundles.
    // --------------------------------------------------

    typedef struct packed {
        logic [`DP_IO_PORTS-1:0]                        ready;
        logic [`DP_IO_PORTS-1:0][`DP_WORD_WIDTH-1:0]    data;
    } io_in_t;

    typedef struct packed {
        logic [`DP_IO_PORTS-1:0]    wren;
        logic [`DP_WORD_WIDTH-1:0]  data;
    } io_out_t;

    // --------------------------------------------------
    // Pipeline payloads.
    // --------------------------------------------------

    typedef struct packed {
        opcode_e                    op;
        logic [`DP_D_WIDTH-1:0]     d;
    } alu_req_t;

    typedef struct packed {
        logic                       write;
        logic [`DP_D_WIDTH-1:0]     d;
        logic [`DP_WORD_WIDTH-1:0]  result;
    } wb_t;

endpackage

// ==== common/datapath_defs.svh ====
`ifndef DATAPATH_DEFS_SVH
`define DATAPATH_DEFS_SVH

// --------------------------------------------------
// Word and instruction field widths.
// --------------------------------------------------

`define DP_WORD_WIDTH       16
`define DP_OP_WIDTH         4
`define DP_D_WIDTH          10
`define DP_AB_WIDTH         9

// --------------------------------------------------
// Bank memory map.
// --------------------------------------------------

`define DP_RAM_DEPTH        256
`define DP_RAM_ADDR_WIDTH   8
`define DP_IO_PORTS         2

// Local addresses 0x1FE and 0x1FF share these upper bits.
`define DP_IO_TAG           8'hFF

`define DP_A_OFFSET         0
`define DP_B_OFFSET         512

`endif
